// File: design/scaler_pkg.sv
`default_nettype none

package scaler_pkg;

	// Pixel width
	localparam int DATA_W = 16;

	// Pixels per line, small for simulation
	localparam int LINE_WIDTH = 8;

	// Position counter must reach LINE_WIDTH itself
	localparam int POS_W = 4;

	// One index bit gives a factor of two
	localparam int REPEAT_W = 1;
	localparam int REPEAT_COUNT = 2 ** REPEAT_W;

	// One line plus a spare word for the write-back slot
	localparam int FIFO_DEPTH = LINE_WIDTH + 1;
	localparam int FIFO_AW = 4;

	typedef logic [DATA_W-1:0] pixel_t;
	typedef logic [POS_W-1:0] line_pos_t;
	typedef logic [REPEAT_W-1:0] repeat_t;

	// Input beat, also the FIFO word
	typedef struct packed {
		pixel_t data;
		logic sop;
		logic eop;
	} stream_beat_t;

	// Output beat with the copy number as channel
	typedef struct packed {
		repeat_t channel;
		pixel_t data;
		logic sop;
		logic eop;
	} out_beat_t;

	// Capture, loop copies back, then drain the last copy
	typedef enum logic [1:0] {
		get_line = 2'd0,
		loop_line = 2'd1,
		last_line = 2'd2
	} height_state_e;

endpackage

`default_nettype wire

// File: design/line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo import scaler_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input stream_beat_t wr_beat,
	input logic rd_en,
	output stream_beat_t rd_beat,
	output logic empty,
	output logic full
);

	// Storage, no reset needed
	stream_beat_t mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW-1:0] count;
	logic do_wr;
	logic do_rd;

	// Wrap at the last slot, depth is not a power of two
	function automatic logic [FIFO_AW-1:0] ptr_next(input logic [FIFO_AW-1:0] p);
		logic [FIFO_AW-1:0] nxt;
		nxt = (p == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
		return nxt;
	endfunction

	// Write while full only if a read frees the head slot
	assign do_wr = wr_en & (~full | rd_en);
	assign do_rd = rd_en & ~empty;

	// Show-ahead head word
	assign rd_beat = mem[rd_ptr];

	assign empty = (count == '0);
	assign full = (count == FIFO_AW'(FIFO_DEPTH));

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_beat;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// Read and write together leave the fill level alone
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/height_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module height_sequencer import scaler_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input stream_beat_t in_beat,
	output logic in_ready,
	input stream_beat_t fifo_head,
	input logic fifo_empty,
	input logic fifo_full,
	output logic fifo_wr,
	output stream_beat_t fifo_wr_beat,
	output logic fifo_rd,
	input logic line_captured,
	input logic line_read_end,
	input logic last_repeat,
	input logic out_load,
	output logic beat_present,
	output height_state_e state
);

	height_state_e next_state;
	logic looping;

	assign looping = (state == loop_line);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= get_line;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			get_line: begin
				// Whole line in the FIFO
				if (line_captured) begin
					next_state = loop_line;
				end
			end
			loop_line: begin
				// Index steps on this edge, so the copy after it is the last
				if (line_read_end & ~last_repeat) begin
					next_state = last_line;
				end
			end
			last_line: begin
				if (line_read_end) begin
					next_state = get_line;
				end
			end
			default: next_state = get_line;
		endcase
	end

	// Nothing is read out while capturing
	assign beat_present = (state != get_line) & ~fifo_empty;
	assign fifo_rd = out_load & beat_present;

	// Blocked while looping or once a full line is held
	assign in_ready = looping ? 1'b0 : (~fifo_full & ~line_captured);

	// Loop mode recirculates the head word into the tail
	assign fifo_wr = looping ? fifo_rd : (in_valid & in_ready);
	assign fifo_wr_beat = looping ? fifo_head : in_beat;

endmodule

`default_nettype wire

// File: design/line_counters.sv
`timescale 1ns/1ps
`default_nettype none

module line_counters import scaler_pkg::*; (
	input logic clk,
	input logic rst_n,
	input height_state_e state,
	input logic in_fire,
	input logic fifo_rd,
	output logic line_captured,
	output logic line_read_end,
	output logic last_repeat,
	output repeat_t repeat_idx
);

	line_pos_t cap_cnt;
	line_pos_t rd_pos;

	// Captured pixels, cleared once the line starts looping
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cap_cnt <= '0;
		end else if (state == loop_line) begin
			cap_cnt <= '0;
		end else if (in_fire) begin
			cap_cnt <= cap_cnt + 1'b1;
		end
	end

	assign line_captured = (cap_cnt == POS_W'(LINE_WIDTH));

	// Read position, wraps at the end of every copy
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pos <= '0;
		end else if (fifo_rd) begin
			if (rd_pos == POS_W'(LINE_WIDTH - 1)) begin
				rd_pos <= '0;
			end else begin
				rd_pos <= rd_pos + 1'b1;
			end
		end
	end

	// Last pixel of a copy leaves the FIFO
	assign line_read_end = fifo_rd & (rd_pos == POS_W'(LINE_WIDTH - 1));

	// Copy number, restarts for every new input line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			repeat_idx <= '0;
		end else if (state == get_line) begin
			repeat_idx <= '0;
		end else if (line_read_end) begin
			repeat_idx <= repeat_idx + 1'b1;
		end
	end

	assign last_repeat = &repeat_idx;

endmodule

`default_nettype wire

// File: design/stream_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module stream_out_stage import scaler_pkg::*; (
	input logic clk,
	input logic rst_n,
	input stream_beat_t fifo_head,
	input repeat_t repeat_idx,
	input logic beat_present,
	input logic out_ready,
	output logic out_load,
	output out_beat_t out_beat,
	output logic out_valid
);

	repeat_t chan_q;
	pixel_t data_q;
	logic sop_q;
	logic eop_q;
	logic first_copy;
	logic final_copy;

	// Register free or being emptied this cycle
	assign out_load = out_ready | ~out_valid;

	assign first_copy = (repeat_idx == '0);
	assign final_copy = &repeat_idx;

	// Valid and packet flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			sop_q <= 1'b0;
			eop_q <= 1'b0;
		end else if (out_load) begin
			out_valid <= beat_present;
			// sop only on copy zero
			sop_q <= first_copy ? fifo_head.sop : 1'b0;
			// eop only on the final copy
			eop_q <= final_copy ? fifo_head.eop : 1'b0;
		end
	end

	// Pixel and channel payload
	always_ff @(posedge clk) begin
		if (out_load) begin
			chan_q <= repeat_idx;
			data_q <= fifo_head.data;
		end
	end

	assign out_beat = '{channel: chan_q, data: data_q, sop: sop_q, eop: eop_q};

endmodule

`default_nettype wire

// File: design/video_scaler_height.sv
`timescale 1ns/1ps
`default_nettype none

module video_scaler_height import scaler_pkg::*; (
	input logic clk,
	input logic rst_n,
	input stream_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,
	output out_beat_t out_beat,
	output logic out_valid,
	input logic out_ready
);

	// FIFO side
	stream_beat_t fifo_head;
	stream_beat_t fifo_wr_beat;
	logic fifo_wr;
	logic fifo_rd;
	logic fifo_empty;
	logic fifo_full;

	// Counter flags
	logic line_captured;
	logic line_read_end;
	logic last_repeat;
	repeat_t repeat_idx;

	// Sequencer and output handshake
	height_state_e state;
	logic beat_present;
	logic out_load;
	logic in_fire;

	// Accepted input beat
	assign in_fire = in_valid & in_ready;

	line_fifo u_line_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(fifo_wr),
		.wr_beat(fifo_wr_beat),
		.rd_en(fifo_rd),
		.rd_beat(fifo_head),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	height_sequencer u_height_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_beat(in_beat),
		.in_ready(in_ready),
		.fifo_head(fifo_head),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full),
		.fifo_wr(fifo_wr),
		.fifo_wr_beat(fifo_wr_beat),
		.fifo_rd(fifo_rd),
		.line_captured(line_captured),
		.line_read_end(line_read_end),
		.last_repeat(last_repeat),
		.out_load(out_load),
		.beat_present(beat_present),
		.state(state)
	);

	line_counters u_line_counters (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.in_fire(in_fire),
		.fifo_rd(fifo_rd),
		.line_captured(line_captured),
		.line_read_end(line_read_end),
		.last_repeat(last_repeat),
		.repeat_idx(repeat_idx)
	);

	// Registered output, channel carries the copy number
	stream_out_stage u_stream_out_stage (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_head(fifo_head),
		.repeat_idx(repeat_idx),
		.beat_present(beat_present),
		.out_ready(out_ready),
		.out_load(out_load),
		.out_beat(out_beat),
		.out_valid(out_valid)
	);

endmodule

`default_nettype wire

// File: testbench/tb_video_scaler_height.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_scaler_height import scaler_pkg::*; ();

	// Cycles any single wait may take before giving up
	localparam int WAIT_LIMIT = 1000;

	logic clk;
	logic rst_n;
	stream_beat_t in_beat;
	logic in_valid;
	logic in_ready;
	out_beat_t out_beat;
	logic out_valid;
	logic out_ready;

	// Frames from the cases file
	int height_q[$];
	int start_q[$];

	// Expected output and the sink mode that applies to each beat
	out_beat_t expected_q[$];
	bit mode_q[$];
	int beats_expected;
	int beats_seen;
	int seed;

	video_scaler_height uut (
		.clk(clk),
		.rst_n(rst_n),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_field(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("MISMATCH time=%0t ns signal=%s expected=0x%0h actual=0x%0h",
				$time, name, expected, actual));
		end
	endtask

	// Each line appears REPEAT_COUNT times with the copy index on the channel
	task automatic add_expected(input int height, input int start, input bit mode);
		out_beat_t beat;
		for (int ln = 0; ln < height; ln++) begin
			for (int copy = 0; copy < REPEAT_COUNT; copy++) begin
				for (int px = 0; px < LINE_WIDTH; px++) begin
					beat.channel = repeat_t'(copy);
					beat.data = pixel_t'(start + ln * LINE_WIDTH + px);
					// Frame start only on the very first beat out
					beat.sop = (ln == 0) && (copy == 0) && (px == 0);
					// Frame end only on the last copy of the last line
					beat.eop = (ln == height - 1) && (copy == REPEAT_COUNT - 1) &&
						(px == LINE_WIDTH - 1);
					expected_q.push_back(beat);
					mode_q.push_back(mode);
				end
			end
		end
		beats_expected += height * LINE_WIDTH * REPEAT_COUNT;
	endtask

	task automatic load_cases();
		int fd;
		int n;
		int height;
		int start;
		int mode;
		string text;
		fd = $fopen("testbench/scaler_cases.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open testbench/scaler_cases.txt");
		end
		while (!$feof(fd)) begin
			if ($fgets(text, fd) != 0) begin
				// Comment lines do not parse and drop out here
				n = $sscanf(text, "%d %h %d", height, start, mode);
				if (n == 3) begin
					height_q.push_back(height);
					start_q.push_back(start);
					add_expected(height, start, mode[0]);
				end
			end
		end
		$fclose(fd);
		if (height_q.size() == 0) begin
			abort_run("The cases file holds no usable case");
		end
	endtask

	// Pixels count up from the start value with flags on first and last beat
	task automatic send_frame(input int height, input int start);
		int total;
		int waited;
		total = height * LINE_WIDTH;
		for (int i = 0; i < total; i++) begin
			@(negedge clk);
			in_beat = '{data: pixel_t'(start + i), sop: (i == 0), eop: (i == total - 1)};
			in_valid = 1'b1;
			waited = 0;
			// Hold the beat until the DUT takes it
			while (!in_ready) begin
				@(negedge clk);
				waited++;
				if (waited > WAIT_LIMIT) begin
					abort_run($sformatf("Timeout at %0t ns: in_ready stayed low too long",
						$time));
				end
			end
		end
	endtask

	task automatic send_all();
		for (int k = 0; k < height_q.size(); k++) begin
			send_frame(height_q[k], start_q[k]);
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic collect_output();
		out_beat_t held;
		out_beat_t exp_beat;
		logic stalled;
		int idle;
		int r;
		stalled = 1'b0;
		idle = 0;
		while (expected_q.size() > 0) begin
			@(negedge clk);
			// A refused beat must still be there unchanged
			if (stalled) begin
				check_field("out_valid", 32'(1'b1), 32'(out_valid));
				check_field("out_beat", 32'(held), 32'(out_beat));
			end
			if (mode_q[0]) begin
				r = $random(seed);
				out_ready = r[0];
			end else begin
				out_ready = 1'b1;
			end
			// Transfer happens on the coming rising edge
			if (out_valid && out_ready) begin
				exp_beat = expected_q.pop_front();
				void'(mode_q.pop_front());
				check_field("out_beat.channel", 32'(exp_beat.channel), 32'(out_beat.channel));
				check_field("out_beat.data", 32'(exp_beat.data), 32'(out_beat.data));
				check_field("out_beat.sop", 32'(exp_beat.sop), 32'(out_beat.sop));
				check_field("out_beat.eop", 32'(exp_beat.eop), 32'(out_beat.eop));
				beats_seen++;
				stalled = 1'b0;
				idle = 0;
			end else begin
				stalled = out_valid;
				held = out_beat;
				idle++;
				if (idle > WAIT_LIMIT) begin
					abort_run($sformatf("Timeout at %0t ns: no output beat arrived in time",
						$time));
				end
			end
		end
		@(negedge clk);
		out_ready = 1'b1;
	endtask

	initial begin
		rst_n = 1'b0;
		in_beat = '0;
		in_valid = 1'b0;
		out_ready = 1'b1;
		seed = 22619;
		beats_expected = 0;
		beats_seen = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		// Idle after reset and ready for a line
		check_field("out_valid", 32'(1'b0), 32'(out_valid));
		check_field("in_ready", 32'(1'b1), 32'(in_ready));
		load_cases();
		fork
			send_all();
			collect_output();
		join
		// Any beat still coming out adds to the total
		repeat (4 * LINE_WIDTH) begin
			@(negedge clk);
			if (out_valid) begin
				beats_seen++;
			end
		end
		check_field("beat_count", 32'(beats_expected), 32'(beats_seen));
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/scaler_cases.txt
# Columns: frame height in lines, first pixel value in hex, back-pressure mode
# Mode 0 keeps out_ready high, mode 1 draws out_ready at random
1 0000 0
3 0100 0
2 fff8 1
4 1234 1
1 abcd 1
2 0040 0
3 7ff0 1

// File: verilog.f
design/scaler_pkg.sv
design/line_fifo.sv
design/height_sequencer.sv
design/line_counters.sv
design/stream_out_stage.sv
design/video_scaler_height.sv
testbench/tb_video_scaler_height.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --timing --timescale 1ns/1ps
TOP ?= tb_video_scaler_height
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
